// ==== filelist.f ====
+incdir+source
source/lp_pkg.sv
source/lp_axil_loader.sv
source/lp_mat_bank.sv
source/lp_dot_engine.sv
source/lp_result_reader.sv
source/lp_top.sv
test/tb_lp_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_lp_top -f filelist.f \
    && ./obj_dir/Vtb_lp_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Checks failed" sim.log \
    && { echo "Simulation reported errors"; exit 1; } \
    || echo "Simulation clean"

// ==== source/lp_axil_loader.sv ====
// ============================================================
// AXI4-Lite write slave
// Decodes writes into A/W row strobes and the start command
// ============================================================
`default_nettype none

`include "lp_consts.svh"

module lp_axil_loader (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire lp_pkg::axil_addr_t awaddr,
    input  wire logic               awvalid,
    output logic                    awready,
    input  wire lp_pkg::axil_data_t wdata,
    input  wire logic [3:0]         wstrb,
    input  wire logic               wvalid,
    output logic                    wready,
    output lp_pkg::axil_resp_t      bresp,
    output logic                    bvalid,
    input  wire logic               bready,
    output logic                    a_we,
    output logic                    w_we,
    output lp_pkg::a_idx_t          wr_row_idx,
    output lp_pkg::row_t            wr_row,
    output logic                    start
);

    logic               accept;
    logic               hs;
    logic               in_ctrl;
    logic               in_a;
    logic               in_w;
    lp_pkg::axil_addr_t row_off;

    // AW and W are taken together in the same cycle
    assign awready = accept;
    assign wready  = accept;
    assign hs      = accept && awvalid && wvalid;

    assign in_ctrl = (awaddr == `LP_CTRL_ADDR);
    assign in_a    = (awaddr >= `LP_A_BASE) && (awaddr < `LP_A_BASE + 4 * `LP_ROWS);
    assign in_w    = (awaddr >= `LP_W_BASE) && (awaddr < `LP_W_BASE + 4 * `LP_COLS);
    assign row_off = awaddr - (in_a ? `LP_A_BASE : `LP_W_BASE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accept <= 1'b0;
            bvalid <= 1'b0;
            a_we   <= 1'b0;
            w_we   <= 1'b0;
            start  <= 1'b0;
        end else begin
            accept <= awvalid && wvalid && !bvalid && !accept;
            a_we   <= hs && in_a;
            w_we   <= hs && in_w;
            start  <= hs && in_ctrl && wdata[0];
            if (hs) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // Byte strobes ignored, whole words written
    always_ff @(posedge clk) begin
        if (hs) begin
            wr_row     <= wdata;
            wr_row_idx <= lp_pkg::a_idx_t'(row_off >> 2);
            bresp      <= (in_ctrl || in_a || in_w) ? `LP_RESP_OKAY : `LP_RESP_SLVERR;
        end
    end

    // ============================================================
    // Checks
    // ============================================================
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

// ==== source/lp_consts.svh ====
// ============================================================
// Linear projection core constants
// Matrix sizes, data widths and the AXI4-Lite address map
// ============================================================
`ifndef LP_CONSTS_SVH
`define LP_CONSTS_SVH

`define LP_INNER    4
`define LP_ROWS     4
`define LP_COLS     4
`define LP_ELEM_W   8
`define LP_ROW_W    (`LP_INNER * `LP_ELEM_W)
`define LP_RES_W    20
`define LP_ADDR_W   12

// Address map
`define LP_CTRL_ADDR    12'h000
`define LP_STATUS_ADDR  12'h004
`define LP_A_BASE       12'h100
`define LP_W_BASE       12'h200
`define LP_C_BASE       12'h300

`define LP_RESP_OKAY    2'b00
`define LP_RESP_SLVERR  2'b10

`endif

// ==== source/lp_dot_engine.sv ====
// ============================================================
// Dot product engine
// Two-stage signed multiply-accumulate over one row pair
// ============================================================
`default_nettype none

`include "lp_consts.svh"

module lp_dot_engine (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             pair_valid,
    input  wire lp_pkg::row_t     pair_a,
    input  wire lp_pkg::row_t     pair_w,
    input  wire lp_pkg::res_idx_t pair_idx,
    output logic                  res_valid,
    output lp_pkg::result_t       res_data,
    output lp_pkg::res_idx_t      res_idx
);

    localparam int PROD_W = 2 * `LP_ELEM_W;

    logic signed [PROD_W-1:0] prod_q [`LP_INNER];
    logic                     prod_valid;
    lp_pkg::res_idx_t         prod_idx;
    lp_pkg::result_t          sum;

    // Stage one, element products
    always_ff @(posedge clk) begin
        for (int k = 0; k < `LP_INNER; k++) begin
            prod_q[k] <= $signed(pair_a[k*`LP_ELEM_W +: `LP_ELEM_W]) *
                         $signed(pair_w[k*`LP_ELEM_W +: `LP_ELEM_W]);
        end
        prod_idx <= pair_idx;
    end

    // Sign-extended adder tree
    always_comb begin
        sum = '0;
        for (int k = 0; k < `LP_INNER; k++) begin
            sum = sum + lp_pkg::result_t'(prod_q[k]);
        end
    end

    // Stage two, accumulated result
    always_ff @(posedge clk) begin
        res_data <= sum;
        res_idx  <= prod_idx;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            res_valid  <= 1'b0;
        end else begin
            prod_valid <= pair_valid;
            res_valid  <= prod_valid;
        end
    end

endmodule

`default_nettype wire

// ==== source/lp_mat_bank.sv ====
// ============================================================
// Matrix bank
// A and W row memories, written in the write phase and then
// swept pair by pair by the read sequencer
// ============================================================
`default_nettype none

`include "lp_consts.svh"

module lp_mat_bank (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire logic           a_we,
    input  wire logic           w_we,
    input  wire lp_pkg::a_idx_t wr_row_idx,
    input  wire lp_pkg::row_t   wr_row,
    input  wire logic           start,
    output logic                pair_valid,
    output lp_pkg::row_t        pair_a,
    output lp_pkg::row_t        pair_w,
    output lp_pkg::res_idx_t    pair_idx,
    output logic                busy,
    output logic                run_start
);

    lp_pkg::row_t        a_mem [`LP_ROWS];
    lp_pkg::row_t        w_mem [`LP_COLS];
    lp_pkg::bank_state_t state;
    lp_pkg::a_idx_t      a_idx;
    lp_pkg::w_idx_t      w_idx;
    logic                last_w;
    logic                last_a;

    assign busy      = (state != lp_pkg::BANK_WRITE);
    assign run_start = start && (state == lp_pkg::BANK_WRITE);
    assign last_w    = (w_idx == lp_pkg::w_idx_t'(`LP_COLS - 1));
    assign last_a    = (a_idx == lp_pkg::a_idx_t'(`LP_ROWS - 1));

    // Host writes only land in the write phase
    always_ff @(posedge clk) begin
        if (a_we && state == lp_pkg::BANK_WRITE) begin
            a_mem[wr_row_idx] <= wr_row;
        end
        if (w_we && state == lp_pkg::BANK_WRITE) begin
            w_mem[lp_pkg::w_idx_t'(wr_row_idx)] <= wr_row;
        end
    end

    // ============================================================
    // Read sequencer
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= lp_pkg::BANK_WRITE;
            a_idx      <= '0;
            w_idx      <= '0;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= 1'b0;
            case (state)
                lp_pkg::BANK_WRITE: begin
                    a_idx <= '0;
                    w_idx <= '0;
                    if (start) state <= lp_pkg::BANK_READ;
                end
                lp_pkg::BANK_READ: begin
                    pair_valid <= 1'b1;
                    // W index runs fast, A index slow
                    w_idx <= last_w ? '0 : w_idx + 1'b1;
                    if (last_w) begin
                        if (last_a) state <= lp_pkg::BANK_DRAIN;
                        else a_idx <= a_idx + 1'b1;
                    end
                end
                default: state <= lp_pkg::BANK_WRITE;
            endcase
        end
    end

    // One-cycle read latency, data lines up with pair_valid
    always_ff @(posedge clk) begin
        pair_a   <= a_mem[a_idx];
        pair_w   <= w_mem[w_idx];
        pair_idx <= lp_pkg::res_idx_t'(a_idx * `LP_COLS + w_idx);
    end

    // Last pair is still visible during drain, never after
    pair_not_in_write: assert property (@(posedge clk) disable iff (!rst_n)
        pair_valid |-> state != lp_pkg::BANK_WRITE);

endmodule

`default_nettype wire

// ==== source/lp_pkg.sv ====
// ============================================================
// Linear projection core types
// Width typedefs and the bank sequencer states
// ============================================================
`default_nettype none

`include "lp_consts.svh"

package lp_pkg;

    typedef logic [`LP_ADDR_W-1:0] axil_addr_t;
    typedef logic [31:0]           axil_data_t;
    typedef logic [1:0]            axil_resp_t;

    // One matrix row, element 0 in the low byte
    typedef logic [`LP_ROW_W-1:0] row_t;

    typedef logic [$clog2(`LP_ROWS)-1:0]            a_idx_t;
    typedef logic [$clog2(`LP_COLS)-1:0]            w_idx_t;
    typedef logic [$clog2(`LP_ROWS*`LP_COLS)-1:0]   res_idx_t;

    typedef logic signed [`LP_RES_W-1:0] result_t;

    typedef enum logic [1:0] {BANK_WRITE, BANK_READ, BANK_DRAIN} bank_state_t;

endpackage

`default_nettype wire

// ==== source/lp_result_reader.sv ====
// ============================================================
// Result reader
// Result memory, run status and the AXI4-Lite read slave
// ============================================================
`default_nettype none

`include "lp_consts.svh"

module lp_result_reader (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               res_valid,
    input  wire lp_pkg::result_t    res_data,
    input  wire lp_pkg::res_idx_t   res_idx,
    input  wire logic               busy,
    input  wire logic               run_start,
    input  wire lp_pkg::axil_addr_t araddr,
    input  wire logic               arvalid,
    output logic                    arready,
    output lp_pkg::axil_data_t      rdata,
    output lp_pkg::axil_resp_t      rresp,
    output logic                    rvalid,
    input  wire logic               rready
);

    localparam int N_RES = `LP_ROWS * `LP_COLS;

    lp_pkg::result_t    res_mem [N_RES];
    logic               done;
    logic               running;
    logic               last_res;
    logic               ar_hs;
    logic               in_status;
    logic               in_res;
    lp_pkg::axil_addr_t res_off;
    lp_pkg::res_idx_t   rd_idx;
    lp_pkg::result_t    rd_res;

    assign last_res = res_valid && (res_idx == lp_pkg::res_idx_t'(N_RES - 1));

    always_ff @(posedge clk) begin
        if (res_valid) res_mem[res_idx] <= res_data;
    end

    // Status stays busy until the pipeline has emptied
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done    <= 1'b0;
            running <= 1'b0;
        end else if (run_start) begin
            done    <= 1'b0;
            running <= 1'b1;
        end else if (last_res) begin
            done    <= 1'b1;
            running <= 1'b0;
        end
    end

    // ============================================================
    // AXI4-Lite read channel
    // ============================================================
    assign arready   = !rvalid;
    assign ar_hs     = arvalid && arready;
    assign in_status = (araddr == `LP_STATUS_ADDR);
    assign in_res    = (araddr >= `LP_C_BASE) && (araddr < `LP_C_BASE + 4 * N_RES);
    assign res_off   = araddr - `LP_C_BASE;
    assign rd_idx    = lp_pkg::res_idx_t'(res_off >> 2);
    assign rd_res    = res_mem[rd_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (ar_hs) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rresp <= `LP_RESP_OKAY;
            if (in_status) begin
                rdata <= {30'b0, busy || running, done};
            end else if (in_res) begin
                rdata <= {{(32 - `LP_RES_W){rd_res[`LP_RES_W-1]}}, rd_res};
            end else begin
                rdata <= '0;
                rresp <= `LP_RESP_SLVERR;
            end
        end
    end

    rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// ==== source/lp_top.sv ====
// ============================================================
// Linear projection core top
// AXI4-Lite loader, matrix bank, dot engine and result reader
// ============================================================
`default_nettype none

module lp_top (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire lp_pkg::axil_addr_t awaddr,
    input  wire logic               awvalid,
    output logic                    awready,
    input  wire lp_pkg::axil_data_t wdata,
    input  wire logic [3:0]         wstrb,
    input  wire logic               wvalid,
    output logic                    wready,
    output lp_pkg::axil_resp_t      bresp,
    output logic                    bvalid,
    input  wire logic               bready,
    input  wire lp_pkg::axil_addr_t araddr,
    input  wire logic               arvalid,
    output logic                    arready,
    output lp_pkg::axil_data_t      rdata,
    output lp_pkg::axil_resp_t      rresp,
    output logic                    rvalid,
    input  wire logic               rready
);

    // Loader to bank
    logic             a_we;
    logic             w_we;
    lp_pkg::a_idx_t   wr_row_idx;
    lp_pkg::row_t     wr_row;
    logic             start;

    // Bank to engine and reader
    logic             pair_valid;
    lp_pkg::row_t     pair_a;
    lp_pkg::row_t     pair_w;
    lp_pkg::res_idx_t pair_idx;
    logic             busy;
    logic             run_start;

    // Engine to reader
    logic             res_valid;
    lp_pkg::result_t  res_data;
    lp_pkg::res_idx_t res_idx;

    lp_axil_loader u_loader (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .a_we, .w_we, .wr_row_idx, .wr_row, .start
    );

    lp_mat_bank u_bank (
        .clk, .rst_n,
        .a_we, .w_we, .wr_row_idx, .wr_row, .start,
        .pair_valid, .pair_a, .pair_w, .pair_idx,
        .busy, .run_start
    );

    lp_dot_engine u_engine (
        .clk, .rst_n,
        .pair_valid, .pair_a, .pair_w, .pair_idx,
        .res_valid, .res_data, .res_idx
    );

    lp_result_reader u_reader (
        .clk, .rst_n,
        .res_valid, .res_data, .res_idx,
        .busy, .run_start,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

endmodule

`default_nettype wire

// ==== test/tb_lp_top.sv ====
// ============================================================
// Linear projection core testbench
// Random matrices over AXI4-Lite, checked against a dot model
// ============================================================
`default_nettype none

`include "lp_consts.svh"

module tb_lp_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED            = 20220;
    localparam int N_RUNS          = 6;
    localparam int N_FIXED_RUNS    = 5;
    localparam int CLK_PERIOD      = 8;
    localparam int WATCHDOG_CYCLES = (N_RUNS + N_FIXED_RUNS) * 400;

    logic               clk;
    logic               rst_n;
    lp_pkg::axil_addr_t awaddr;
    logic               awvalid;
    logic               awready;
    lp_pkg::axil_data_t wdata;
    logic [3:0]         wstrb;
    logic               wvalid;
    logic               wready;
    lp_pkg::axil_resp_t bresp;
    logic               bvalid;
    logic               bready;
    lp_pkg::axil_addr_t araddr;
    logic               arvalid;
    logic               arready;
    lp_pkg::axil_data_t rdata;
    lp_pkg::axil_resp_t rresp;
    logic               rvalid;
    logic               rready;

    // Model copies of the loaded matrices
    lp_pkg::row_t a_rows [`LP_ROWS];
    lp_pkg::row_t w_rows [`LP_COLS];
    int           mismatches;
    int           other_errors;
    lp_pkg::axil_data_t rd_word;
    lp_pkg::axil_resp_t resp;

    lp_top u_dut (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // Reference model
    // ============================================================
    function automatic lp_pkg::result_t model_dot(input int r, input int c);
        int                           acc;
        logic signed [`LP_ELEM_W-1:0] ea;
        logic signed [`LP_ELEM_W-1:0] eb;
        acc = 0;
        for (int k = 0; k < `LP_INNER; k++) begin
            ea  = a_rows[r][k*`LP_ELEM_W +: `LP_ELEM_W];
            eb  = w_rows[c][k*`LP_ELEM_W +: `LP_ELEM_W];
            acc = acc + int'(ea) * int'(eb);
        end
        return lp_pkg::result_t'(acc);
    endfunction

    // Biased towards the extremes of the signed byte range
    function automatic logic [`LP_ELEM_W-1:0] rand_elem();
        int pick;
        pick = $urandom_range(7);
        if (pick == 0) return 8'h80;
        if (pick == 1) return 8'h7f;
        return 8'($urandom);
    endfunction

    function automatic lp_pkg::row_t rand_row();
        lp_pkg::row_t row;
        for (int k = 0; k < `LP_INNER; k++) begin
            row[k*`LP_ELEM_W +: `LP_ELEM_W] = rand_elem();
        end
        return row;
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_result(input lp_pkg::result_t got, input lp_pkg::result_t exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_resp(input lp_pkg::axil_resp_t got, input lp_pkg::axil_resp_t exp,
                              input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s resp %b expected %b", $time, what, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_status(input lp_pkg::axil_data_t got, input lp_pkg::axil_data_t exp,
                                input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // ============================================================
    // AXI4-Lite transactions, called on a falling edge
    // ============================================================
    task automatic axil_write(input lp_pkg::axil_addr_t addr, input lp_pkg::axil_data_t data,
                              output lp_pkg::axil_resp_t wr_resp);
        int delay;
        delay   = $urandom_range(3);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!awready) @(negedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (delay) @(negedge clk);
        wr_resp = bresp;
        bready  = 1'b1;
        @(negedge clk);
        bready  = 1'b0;
    endtask

    task automatic axil_read(input lp_pkg::axil_addr_t addr, output lp_pkg::axil_data_t data,
                             output lp_pkg::axil_resp_t rd_resp);
        int delay;
        delay   = $urandom_range(3);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (delay) @(negedge clk);
        data    = rdata;
        rd_resp = rresp;
        rready  = 1'b1;
        @(negedge clk);
        rready  = 1'b0;
    endtask

    // ============================================================
    // Run helpers
    // ============================================================
    task automatic load_matrices();
        lp_pkg::axil_resp_t wr_resp;
        for (int r = 0; r < `LP_ROWS; r++) begin
            axil_write(`LP_A_BASE + 12'(4 * r), a_rows[r], wr_resp);
            check_resp(wr_resp, `LP_RESP_OKAY, "A row write");
        end
        for (int c = 0; c < `LP_COLS; c++) begin
            axil_write(`LP_W_BASE + 12'(4 * c), w_rows[c], wr_resp);
            check_resp(wr_resp, `LP_RESP_OKAY, "W row write");
        end
    endtask

    task automatic start_run();
        lp_pkg::axil_resp_t wr_resp;
        axil_write(`LP_CTRL_ADDR, 32'h1, wr_resp);
        check_resp(wr_resp, `LP_RESP_OKAY, "start write");
    endtask

    task automatic wait_done();
        lp_pkg::axil_data_t st;
        lp_pkg::axil_resp_t rd_resp;
        int                 polls;
        polls = 0;
        st    = '0;
        while (!st[0] && polls < 60) begin
            axil_read(`LP_STATUS_ADDR, st, rd_resp);
            polls++;
        end
        if (!st[0]) begin
            $display("Timed out at %0t waiting for the done bit", $time);
            other_errors++;
        end else begin
            check_status(st, 32'h1, "status after done");
        end
    endtask

    task automatic check_all_results();
        lp_pkg::axil_data_t data;
        lp_pkg::axil_resp_t rd_resp;
        lp_pkg::result_t    expected;
        for (int r = 0; r < `LP_ROWS; r++) begin
            for (int c = 0; c < `LP_COLS; c++) begin
                axil_read(`LP_C_BASE + 12'(4 * (r * `LP_COLS + c)), data, rd_resp);
                expected = model_dot(r, c);
                check_resp(rd_resp, `LP_RESP_OKAY, "result read");
                check_result(lp_pkg::result_t'(data), expected,
                             $sformatf("C[%0d][%0d]", r, c));
                // Whole word carries the sign of the result
                check_status(data, lp_pkg::axil_data_t'(int'(expected)),
                             $sformatf("C[%0d][%0d] word", r, c));
            end
        end
    endtask

    task automatic randomize_model();
        for (int r = 0; r < `LP_ROWS; r++) a_rows[r] = rand_row();
        for (int c = 0; c < `LP_COLS; c++) w_rows[c] = rand_row();
    endtask

    task automatic fill_model(input logic [7:0] a_val, input logic [7:0] w_val);
        for (int r = 0; r < `LP_ROWS; r++) a_rows[r] = {`LP_INNER{a_val}};
        for (int c = 0; c < `LP_COLS; c++) w_rows[c] = {`LP_INNER{w_val}};
    endtask

    task automatic full_run();
        load_matrices();
        start_run();
        wait_done();
        check_all_results();
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin
        void'($urandom(SEED));
        mismatches   = 0;
        other_errors = 0;
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hf;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        axil_read(`LP_STATUS_ADDR, rd_word, resp);
        check_status(rd_word, 32'h0, "status after reset");

        // Random run, busy seen right after start
        randomize_model();
        load_matrices();
        start_run();
        axil_read(`LP_STATUS_ADDR, rd_word, resp);
        check_status(rd_word, 32'h2, "status right after start");
        wait_done();
        check_all_results();

        // Extreme products
        fill_model(8'h80, 8'h80);
        full_run();
        fill_model(8'h80, 8'h7f);
        full_run();

        // Row writes while busy are dropped
        start_run();
        axil_write(`LP_A_BASE, 32'h01010101, resp);
        check_resp(resp, `LP_RESP_OKAY, "A write while busy");
        axil_write(`LP_W_BASE, 32'h01010101, resp);
        check_resp(resp, `LP_RESP_OKAY, "W write while busy");
        wait_done();
        check_all_results();
        start_run();
        wait_done();
        check_all_results();

        // Unmapped and read-only regions
        axil_write(12'h080, 32'h1234, resp);
        check_resp(resp, `LP_RESP_SLVERR, "unmapped write");
        axil_write(`LP_C_BASE, 32'h1234, resp);
        check_resp(resp, `LP_RESP_SLVERR, "result region write");
        axil_write(`LP_CTRL_ADDR, 32'h0, resp);
        check_resp(resp, `LP_RESP_OKAY, "control write of 0");
        axil_read(`LP_STATUS_ADDR, rd_word, resp);
        check_resp(resp, `LP_RESP_OKAY, "status read");
        check_status(rd_word, 32'h1, "status after control 0");
        axil_read(12'h080, rd_word, resp);
        check_resp(resp, `LP_RESP_SLVERR, "unmapped read");
        check_status(rd_word, 32'h0, "unmapped read data");
        axil_read(`LP_A_BASE, rd_word, resp);
        check_resp(resp, `LP_RESP_SLVERR, "A region read");
        check_status(rd_word, 32'h0, "A region read data");

        // Back-to-back random runs
        for (int n = 0; n < N_RUNS; n++) begin
            randomize_model();
            full_run();
        end

        $display("Summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
